//--- verilog/time_dmr_params.svh
`ifndef TIME_DMR_PARAMS_SVH
`define TIME_DMR_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths

// Width of the tag that pairs the two copies of one item
`define TDMR_ID_W 1

// Width of each operand and of the result
`define TDMR_OP_W 16

//////////////////////////////////////////////////////////////////////
// Register block

// Fault counter width, also the register data width
`define TDMR_CNT_W 16

// Control register holds enable in bit 0 and inject arm in bit 1
`define TDMR_ADDR_CTRL 1'b0

// Saturating count of detected faults, cleared by any write
`define TDMR_ADDR_FAULTS 1'b1

`endif

//--- verilog/time_dmr_voters.svh
`ifndef TIME_DMR_VOTERS_SVH
`define TIME_DMR_VOTERS_SVH

//////////////////////////////////////////////////////////////////////
// Majority voters for triplicated state
//
// Both macros work bitwise, so any packed element type can be voted
// Expansion is a statement list for use inside always_comb

// Three replicas reduced to a single voted value
`define VOTE3TO1(rep, res) \
    res = (rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]);

// Three replicas voted and fanned back out to three copies
// Used for next state so a single upset is scrubbed on the next edge
`define VOTE3TO3(rep, res) \
    res[0] = (rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]); \
    res[1] = (rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]); \
    res[2] = (rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]);

`endif

//--- verilog/time_dmr_pkg.sv
`include "time_dmr_params.svh"

package time_dmr_pkg;

    //////////////////////////////////////////////////////////////////////
    // Redundancy control types

    // Tag shared by both copies of one item
    // Toggles per item, enough for an in-order datapath
    typedef logic [`TDMR_ID_W-1:0] tdmr_id_t;

    // Register access from software
    typedef struct packed {
        logic                   we;
        logic                   addr;
        logic [`TDMR_CNT_W-1:0] wdata;
    } reg_req_t;

    // Live configuration seen by the datapath blocks
    typedef struct packed {
        logic enable;   // Issue two copies and compare them
        logic inject;   // Flip one bit of the next second copy
    } tdmr_cfg_t;

endpackage

//--- verilog/mac_pkg.sv
`include "time_dmr_params.svh"

package mac_pkg;

    //////////////////////////////////////////////////////////////////////
    // Arithmetic payload types

    // One operand set for a*b+c
    typedef struct packed {
        logic [`TDMR_OP_W-1:0] a;
        logic [`TDMR_OP_W-1:0] b;
        logic [`TDMR_OP_W-1:0] c;
    } mac_operands_t;

    // Result keeps the low half only
    // Wraps modulo 2^TDMR_OP_W
    typedef struct packed {
        logic [`TDMR_OP_W-1:0] sum;
    } mac_result_t;

endpackage

//--- verilog/time_dmr_start.sv
`timescale 1ns/1ps

module time_dmr_start import time_dmr_pkg::*; #(
    // Item type sent twice through the shared datapath
    parameter type payload_t = logic
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  tdmr_cfg_t cfg_i,

    // Upstream
    input  payload_t  data_i,
    input  logic      valid_i,
    output logic      ready_o,

    // Toward the shared datapath
    output payload_t  data_o,
    output tdmr_id_t  id_o,
    output logic      valid_o,
    input  logic      ready_i
);

    payload_t data_q;
    tdmr_id_t id_q;
    logic     full_q;
    // Low while copy 0 is pending, high for copy 1
    logic     copy_q;
    logic     accept;
    logic     issued;

    // Only one item is held, a new one waits until both copies left
    assign ready_o = ~full_q;
    assign accept  = valid_i & ready_o;
    assign issued  = valid_o & ready_i;

    assign data_o  = data_q;
    assign id_o    = id_q;
    assign valid_o = full_q;

    //////////////////////////////////////////////////////////////////////
    // Copy sequencing

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
        if (!rst_ni) begin
            full_q <= 1'b0;
            copy_q <= 1'b0;
            id_q   <= '0;
        end else if (accept) begin
            // Fresh tag per item, both copies share it
            full_q <= 1'b1;
            copy_q <= 1'b0;
            id_q   <= id_q + 1'b1;
        end else if (issued) begin
            if (cfg_i.enable && !copy_q) begin
                copy_q <= 1'b1;
            end else begin
                // Second copy gone, or single pass when disabled
                full_q <= 1'b0;
                copy_q <= 1'b0;
            end
        end
    end

    // Held item
    always_ff @(posedge clk_i) begin : data_ff
        if (accept) begin
            data_q <= data_i;
        end
    end

    // Copy must not change under back-pressure
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable(data_o) && $stable(id_o));

endmodule

//--- verilog/mac_pipeline.sv
`timescale 1ns/1ps
`include "time_dmr_params.svh"

module mac_pipeline import time_dmr_pkg::*, mac_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  tdmr_cfg_t     cfg_i,

    // Issue side
    input  mac_operands_t op_i,
    input  tdmr_id_t      id_i,
    input  logic          valid_i,
    output logic          ready_o,

    // Result side
    output mac_result_t   res_o,
    output tdmr_id_t      id_o,
    output logic          valid_o,
    input  logic          ready_i,

    // Pulse when the armed bit flip was applied
    output logic          inject_taken_o
);

    logic [`TDMR_OP_W-1:0] s1_prod_q;
    logic [`TDMR_OP_W-1:0] s1_c_q;
    logic [`TDMR_OP_W-1:0] s2_sum_q;
    tdmr_id_t              s1_id_q;
    tdmr_id_t              s2_id_q;
    logic                  s1_valid_q;
    logic                  s2_valid_q;
    logic                  s1_en;
    logic                  s2_en;
    // Next item leaving is the second copy of its pair
    logic                  second_q;
    logic                  inject_now;

    // A stage loads when the one after it is empty or draining
    assign s2_en   = ~s2_valid_q | ready_i;
    assign s1_en   = ~s1_valid_q | s2_en;
    assign ready_o = s1_en;

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            second_q   <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_valid_q <= valid_i;
            end
            if (s2_en) begin
                s2_valid_q <= s1_valid_q;
            end
            // Pair parity only advances in redundant mode
            if (valid_o && ready_i && cfg_i.enable) begin
                second_q <= ~second_q;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Arithmetic

    always_ff @(posedge clk_i) begin : data_ff
        // Stage one, low half of the product
        if (s1_en && valid_i) begin
            s1_prod_q <= op_i.a * op_i.b;
            s1_c_q    <= op_i.c;
            s1_id_q   <= id_i;
        end
        // Stage two, accumulate
        if (s2_en && s1_valid_q) begin
            s2_sum_q <= s1_prod_q + s1_c_q;
            s2_id_q  <= s1_id_q;
        end
    end

    // Fault point on result bit 0 of a second copy
    assign inject_now     = cfg_i.enable & cfg_i.inject & second_q & s2_valid_q;
    assign inject_taken_o = inject_now & ready_i;

    assign res_o.sum = s2_sum_q ^ {{(`TDMR_OP_W-1){1'b0}}, inject_now};
    assign id_o      = s2_id_q;
    assign valid_o   = s2_valid_q;

endmodule

//--- verilog/time_dmr_end.sv
`timescale 1ns/1ps
`include "time_dmr_voters.svh"

module time_dmr_end import time_dmr_pkg::*; #(
    // Item type returned by the shared datapath
    parameter type payload_t = logic
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  tdmr_cfg_t cfg_i,

    // From the shared datapath
    input  payload_t  data_i,
    input  tdmr_id_t  id_i,
    input  logic      valid_i,
    output logic      ready_o,

    // Downstream
    output payload_t  data_o,
    output logic      valid_o,
    output logic      faulty_o,
    input  logic      ready_i,

    // One pulse per faulty result taken downstream
    output logic      fault_o
);

    localparam logic [1:0] ST_BASE        = 2'd0;
    localparam logic [1:0] ST_WAIT_READY  = 2'd1;
    localparam logic [1:0] ST_WAIT_SECOND = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // Stored copy 0

    // Single data register, compared against the incoming copy 1
    payload_t        data_q;
    tdmr_id_t  [2:0] id_v;
    tdmr_id_t  [2:0] id_d;
    tdmr_id_t  [2:0] id_q;
    logic      [2:0] store_v;
    logic            store_en;
    logic            data_diff;

    assign data_diff = (data_i != data_q);

    always_ff @(posedge clk_i) begin : data_ff
        if (store_en) begin
            data_q <= data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Triplicated pairing FSM

    logic [2:0][1:0] state_v;
    logic [2:0][1:0] state_d;
    logic [2:0][1:0] state_q;
    logic [2:0]      valid_v;
    logic [2:0]      ready_v;
    logic [2:0]      faulty_v;
    logic [2:0]      id_match;
    // Voted views of the current state
    logic [1:0]      state_now;
    tdmr_id_t        id_now;

    for (genvar r = 0; r < 3; r++) begin : gen_rep
        always_comb begin : rep_comb
            id_match[r] = (id_i == id_q[r]);
            state_v[r]  = state_q[r];
            store_v[r]  = 1'b0;
            valid_v[r]  = 1'b0;
            ready_v[r]  = 1'b1;
            if (!cfg_i.enable) begin
                // Single pass, no pairing
                valid_v[r] = valid_i;
                ready_v[r] = ready_i;
            end else begin
                case (state_q[r])
                    ST_BASE: begin
                        // Copy 0 absorbed silently
                        store_v[r] = valid_i;
                        if (valid_i) begin
                            state_v[r] = ST_WAIT_SECOND;
                        end
                    end
                    ST_WAIT_SECOND: begin
                        if (id_match[r]) begin
                            // Copy 1 here, present the compared result now
                            valid_v[r] = valid_i;
                            ready_v[r] = ready_i;
                            if (valid_i) begin
                                state_v[r] = ready_i ? ST_BASE : ST_WAIT_READY;
                            end
                        end else begin
                            // Stray tag restarts the pair
                            store_v[r] = valid_i;
                        end
                    end
                    ST_WAIT_READY: begin
                        // Copy 1 held upstream until downstream takes it
                        valid_v[r] = valid_i;
                        ready_v[r] = ready_i;
                        if (valid_i && ready_i) begin
                            state_v[r] = ST_BASE;
                        end
                    end
                    default: begin
                        ready_v[r] = 1'b0;
                        state_v[r] = ST_BASE;
                    end
                endcase
            end
            faulty_v[r] = valid_v[r] & cfg_i.enable & data_diff;
            id_v[r]     = store_v[r] ? id_i : id_q[r];
        end
    end

    // Vote every cycle, single upsets are scrubbed at the next edge
    always_comb begin : vote_comb
        `VOTE3TO3(state_v, state_d)
        `VOTE3TO3(id_v, id_d)
        `VOTE3TO1(store_v, store_en)
        `VOTE3TO1(valid_v, valid_o)
        `VOTE3TO1(ready_v, ready_o)
        `VOTE3TO1(faulty_v, faulty_o)
        `VOTE3TO1(state_q, state_now)
        `VOTE3TO1(id_q, id_now)
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
        if (!rst_ni) begin
            state_q <= {3{ST_BASE}};
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
        end
    end

    // Result comes from the stored first copy
    assign data_o  = cfg_i.enable ? data_q : data_i;
    assign fault_o = faulty_o & valid_o & ready_i;

    // Nothing leaves while copy 0 waits for its partner
    a_quiet_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_now == ST_WAIT_SECOND) && !(valid_i && (id_i == id_now)) |-> !valid_o);

    a_faulty_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        faulty_o |-> valid_o);

endmodule

//--- verilog/time_dmr_cfg.sv
`timescale 1ns/1ps
`include "time_dmr_params.svh"

module time_dmr_cfg import time_dmr_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  reg_req_t               reg_req_i,
    output logic [`TDMR_CNT_W-1:0] rdata_o,
    input  logic                   inject_taken_i,
    input  logic                   fault_i,
    output tdmr_cfg_t              cfg_o
);

    tdmr_cfg_t              cfg_q;
    logic [`TDMR_CNT_W-1:0] fault_cnt_q;
    logic                   ctrl_we;
    logic                   cnt_we;
    logic                   cnt_full;

    assign ctrl_we  = reg_req_i.we && (reg_req_i.addr == `TDMR_ADDR_CTRL);
    assign cnt_we   = reg_req_i.we && (reg_req_i.addr == `TDMR_ADDR_FAULTS);
    assign cnt_full = &fault_cnt_q;

    //////////////////////////////////////////////////////////////////////
    // Control and fault counter

    always_ff @(posedge clk_i or negedge rst_ni) begin : regs_ff
        if (!rst_ni) begin
            // Redundancy on out of reset
            cfg_q.enable <= 1'b1;
            cfg_q.inject <= 1'b0;
            fault_cnt_q  <= '0;
        end else begin
            // One-shot arm, dropped once the pipeline used it
            if (inject_taken_i) begin
                cfg_q.inject <= 1'b0;
            end
            if (ctrl_we) begin
                cfg_q.enable <= reg_req_i.wdata[0];
                cfg_q.inject <= reg_req_i.wdata[1];
            end
            // Sticks at all ones
            if (cnt_we) begin
                fault_cnt_q <= '0;
            end else if (fault_i && !cnt_full) begin
                fault_cnt_q <= fault_cnt_q + 1'b1;
            end
        end
    end

    // Combinational read-back
    assign rdata_o = (reg_req_i.addr == `TDMR_ADDR_CTRL) ?
                     {{(`TDMR_CNT_W-2){1'b0}}, cfg_q.inject, cfg_q.enable} : fault_cnt_q;
    assign cfg_o   = cfg_q;

endmodule

//--- verilog/time_dmr_mac_top.sv
`timescale 1ns/1ps
`include "time_dmr_params.svh"

module time_dmr_mac_top import time_dmr_pkg::*, mac_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // Operand input
    input  mac_operands_t          in_data_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,

    // Checked result
    output mac_result_t            out_data_o,
    output logic                   out_valid_o,
    output logic                   out_faulty_o,
    input  logic                   out_ready_i,

    // Register access
    input  reg_req_t               reg_req_i,
    output logic [`TDMR_CNT_W-1:0] reg_rdata_o
);

    tdmr_cfg_t     cfg;
    // Start to pipeline
    mac_operands_t issue_data;
    tdmr_id_t      issue_id;
    logic          issue_valid;
    logic          issue_ready;
    // Pipeline to end
    mac_result_t   exec_res;
    tdmr_id_t      exec_id;
    logic          exec_valid;
    logic          exec_ready;
    // Status back to the register block
    logic          inject_taken;
    logic          fault;

    time_dmr_cfg i_cfg (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .reg_req_i      (reg_req_i),
        .rdata_o        (reg_rdata_o),
        .inject_taken_i (inject_taken),
        .fault_i        (fault),
        .cfg_o          (cfg)
    );

    time_dmr_start #(
        .payload_t (mac_operands_t)
    ) i_start (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .cfg_i   (cfg),
        .data_i  (in_data_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .data_o  (issue_data),
        .id_o    (issue_id),
        .valid_o (issue_valid),
        .ready_i (issue_ready)
    );

    mac_pipeline i_pipeline (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cfg_i          (cfg),
        .op_i           (issue_data),
        .id_i           (issue_id),
        .valid_i        (issue_valid),
        .ready_o        (issue_ready),
        .res_o          (exec_res),
        .id_o           (exec_id),
        .valid_o        (exec_valid),
        .ready_i        (exec_ready),
        .inject_taken_o (inject_taken)
    );

    time_dmr_end #(
        .payload_t (mac_result_t)
    ) i_end (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .cfg_i    (cfg),
        .data_i   (exec_res),
        .id_i     (exec_id),
        .valid_i  (exec_valid),
        .ready_o  (exec_ready),
        .data_o   (out_data_o),
        .valid_o  (out_valid_o),
        .faulty_o (out_faulty_o),
        .ready_i  (out_ready_i),
        .fault_o  (fault)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 100,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    // Free running clock, half period high
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

//--- verification/tb_time_dmr_mac.sv
`timescale 1ns/1ps
`include "time_dmr_params.svh"

module tb_time_dmr_mac import time_dmr_pkg::*, mac_pkg::*; ;

    localparam int unsigned TIMEOUT_CYCLES = 1000;

    logic                   clk;
    logic                   rst_n;
    mac_operands_t          in_data_i;
    logic                   in_valid_i;
    logic                   in_ready_o;
    mac_result_t            out_data_o;
    logic                   out_valid_o;
    logic                   out_faulty_o;
    logic                   out_ready_i;
    reg_req_t               reg_req_i;
    logic [`TDMR_CNT_W-1:0] reg_rdata_o;

    integer                 seed = 32'h0140_ba0e;
    // Expected sums per accepted input with the oldest first
    logic [`TDMR_OP_W-1:0]  expect_q[$];
    logic                   random_ready;
    logic                   allow_fault;
    int unsigned            results_seen;
    int unsigned            faulty_seen;
    int unsigned            value_errors;
    int unsigned            protocol_errors;
    int unsigned            timeout_errors;

    tb_clock_gen clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    time_dmr_mac_top dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .in_data_i    (in_data_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .out_data_o   (out_data_o),
        .out_valid_o  (out_valid_o),
        .out_faulty_o (out_faulty_o),
        .out_ready_i  (out_ready_i),
        .reg_req_i    (reg_req_i),
        .reg_rdata_o  (reg_rdata_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and result scoreboard

    // a*b+c computed wide and then wrapped to the result width
    function automatic logic [`TDMR_OP_W-1:0] expected_sum(input mac_operands_t op);
        logic [31:0] full;
        full = 32'(op.a) * 32'(op.b) + 32'(op.c);
        return full[`TDMR_OP_W-1:0];
    endfunction

    // Downstream ready is either always high or a random pattern
    always @(posedge clk) begin : drive_ready
        if (random_ready) begin
            out_ready_i <= (($random(seed) & 3) != 0);
        end else begin
            out_ready_i <= 1'b1;
        end
    end

    // Sampled mid-cycle so a handshake seen here completes at the next edge
    always @(negedge clk) begin : monitor_results
        logic [`TDMR_OP_W-1:0] exp_sum;
        if (rst_n) begin
            assert (!out_faulty_o || out_valid_o) else begin
                protocol_errors++;
                $display("Fault flag raised without a valid result at %0t ns", $time);
            end
            if (out_valid_o && out_ready_i) begin
                results_seen++;
                if (out_faulty_o) begin
                    faulty_seen++;
                end
                assert (allow_fault || !out_faulty_o) else begin
                    value_errors++;
                    $display("[FAIL] %0t: fault flag on a result where none is expected", $time);
                end
                if (expect_q.size() == 0) begin
                    protocol_errors++;
                    $display("A result %h came out with no input pending", out_data_o.sum);
                end else begin
                    exp_sum = expect_q.pop_front();
                    assert (out_data_o.sum == exp_sum) else begin
                        value_errors++;
                        $display("[FAIL] %0t: result %h, expected %h",
                                 $time, out_data_o.sum, exp_sum);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks

    // Offer one item and hold it until the DUT takes it
    task automatic send_item(input mac_operands_t op);
        int unsigned waited;
        logic        accepted;
        @(posedge clk);
        in_data_i  <= op;
        in_valid_i <= 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (in_ready_o) begin
                accepted = 1'b1;
                expect_q.push_back(expected_sum(op));
            end
            @(posedge clk);
            waited++;
        end
        in_valid_i <= 1'b0;
        if (!accepted) begin
            timeout_errors++;
            $display("Timeout: the input was never accepted at %0t ns", $time);
        end
    endtask

    task automatic send_random(input int unsigned count);
        mac_operands_t op;
        for (int unsigned i = 0; i < count; i++) begin
            op.a = 16'($random(seed));
            op.b = 16'($random(seed));
            op.c = 16'($random(seed));
            send_item(op);
        end
    endtask

    // Wait until every predicted result has come out
    task automatic wait_drained();
        int unsigned waited;
        waited = 0;
        while (expect_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            timeout_errors++;
            $display("Timeout: %0d results never came out", expect_q.size());
        end
    endtask

    task automatic reg_write(input logic addr, input logic [`TDMR_CNT_W-1:0] data);
        @(posedge clk);
        reg_req_i <= {1'b1, addr, data};
        @(posedge clk);
        reg_req_i.we <= 1'b0;
    endtask

    // Read-back is combinational and taken mid-cycle
    task automatic check_reg(input logic addr, input logic [`TDMR_CNT_W-1:0] exp,
                             input string what);
        logic [`TDMR_CNT_W-1:0] got;
        @(posedge clk);
        reg_req_i <= {1'b0, addr, {`TDMR_CNT_W{1'b0}}};
        @(negedge clk);
        got = reg_rdata_o;
        assert (got == exp) else begin
            value_errors++;
            $display("[FAIL] %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int unsigned got, input int unsigned exp,
                               input string what);
        assert (got == exp) else begin
            value_errors++;
            $display("[FAIL] %0t: wrong number of %s, saw %0d, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin : main_sequence
        int unsigned waited;
        in_data_i       = '0;
        in_valid_i      = 1'b0;
        out_ready_i     = 1'b1;
        reg_req_i       = '0;
        random_ready    = 1'b0;
        allow_fault     = 1'b0;
        results_seen    = 0;
        faulty_seen     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        timeout_errors  = 0;

        waited = 0;
        while (!rst_n && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            timeout_errors++;
            $display("Timeout: reset was never released");
        end

        // Idle outputs out of reset
        @(negedge clk);
        assert (!out_valid_o && !out_faulty_o && in_ready_o) else begin
            value_errors++;
            $display("[FAIL] %0t: idle state wrong after reset", $time);
        end
        check_reg(`TDMR_ADDR_FAULTS, 16'd0, "fault counter after reset");

        // Redundant mode with ready always high
        results_seen = 0;
        send_random(50);
        wait_drained();
        check_count(results_seen, 50, "results with ready held high");

        // Random back-pressure
        results_seen = 0;
        random_ready = 1'b1;
        send_random(50);
        wait_drained();
        random_ready = 1'b0;
        check_count(results_seen, 50, "results under back-pressure");

        // One-shot injection with data still from the intact copy
        faulty_seen = 0;
        allow_fault = 1'b1;
        reg_write(`TDMR_ADDR_CTRL, 16'h0003);
        send_random(10);
        wait_drained();
        allow_fault = 1'b0;
        check_count(faulty_seen, 1, "faulty results after one injection");
        check_reg(`TDMR_ADDR_CTRL, 16'h0001, "control after injection");
        check_reg(`TDMR_ADDR_FAULTS, 16'd1, "fault counter after injection");
        reg_write(`TDMR_ADDR_FAULTS, 16'h0000);
        check_reg(`TDMR_ADDR_FAULTS, 16'd0, "fault counter after clear");

        // Single pass with injection armed where no flag may rise
        results_seen = 0;
        reg_write(`TDMR_ADDR_CTRL, 16'h0002);
        random_ready = 1'b1;
        send_random(20);
        wait_drained();
        random_ready = 1'b0;
        check_count(results_seen, 20, "results in single pass mode");
        check_reg(`TDMR_ADDR_FAULTS, 16'd0, "fault counter in single pass mode");

        repeat (4) @(posedge clk);
        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- time_dmr_mac.f
+incdir+verilog
verilog/time_dmr_pkg.sv
verilog/mac_pkg.sv
verilog/time_dmr_start.sv
verilog/mac_pipeline.sv
verilog/time_dmr_end.sv
verilog/time_dmr_cfg.sv
verilog/time_dmr_mac_top.sv
verification/tb_clock_gen.sv
verification/tb_time_dmr_mac.sv

//--- Makefile
# Verilator flow for the time-redundant multiply-add unit

VERILATOR ?= verilator
TOP       ?= tb_time_dmr_mac
LINT_TOP  ?= time_dmr_mac_top
FILELIST  ?= time_dmr_mac.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit code
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
